// File: merge_pkg.sv
// Shared widths, packet and descriptor types for the merge data generator
// Lane 0 is the main lane and is always part of a merge
// Only fields 1 and 2 can be taken from the other lanes
// Lane FIFO depth also sets the initial credit count of each producer

package merge_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int num_lanes  = 3;
    localparam int num_fields = 4;
    localparam int field_w    = 16;
    localparam int meta_w     = 16;
    localparam int count_w    = 16;

    // Lane FIFO depth equals the producer credit budget
    localparam int lane_fifo_depth = 4;

    // Output FIFO and its pause threshold
    localparam int out_fifo_depth        = 8;
    localparam int out_almost_full_level = 6;

    // ------------------------------
    // Scalar types
    // ------------------------------
    typedef logic [field_w-1:0]   field_t;
    typedef logic [meta_w-1:0]    meta_t;
    typedef logic [count_w-1:0]   count_t;
    typedef logic [num_lanes-1:0] lane_vec_t;

    // ------------------------------
    // Packets and descriptor
    // ------------------------------
    typedef struct packed {
        meta_t                        meta;
        field_t [num_fields-1:0]      field;
    } packet_t;

    typedef packet_t [num_lanes-1:0] lane_packets_t;

    // Bit 0 of the mask is ignored, lane 0 always merges
    typedef struct packed {
        lane_vec_t merge_mask;
        count_t    packet_count;
    } merge_descriptor_t;

    // Run control states
    typedef enum logic [2:0] {
        IDLE,
        BUSY,
        PAUSE,
        DRAIN,
        DONE
    } merge_state_t;

endpackage

// File: packet_fifo.sv
// Synchronous first-word-fall-through FIFO for merge packets
// head is valid whenever empty is low
// depth must be at least 2
// A push into a full FIFO is dropped, a pop of an empty FIFO is ignored
// almost_full is high while the fill level is at or above almost_full_level

`timescale 1ns/1ps

module packet_fifo #(
    parameter int depth             = 4,
    parameter int almost_full_level = depth
) (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               push,
    input  merge_pkg::packet_t push_data,
    input  logic               pop,
    output merge_pkg::packet_t head,
    output logic               empty,
    output logic               almost_full
);

    import merge_pkg::*;

    packet_t mem [depth];

    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] fill;
    logic                       full;
    logic                       do_push;
    logic                       do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // ------------------------------
    // Pointers and fill level
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head        = mem[rd_ptr];
    assign empty       = (fill == '0);
    assign full        = (int'(fill) == depth);
    assign almost_full = (int'(fill) >= almost_full_level);

endmodule

// File: merge_control.sv
// Run control for one merge run
// A start is taken only in IDLE, i.e. while busy is low
// A packet_count of zero goes straight to the drain phase
// Merging stops at once while the output FIFO is almost full
// done is a one-cycle pulse after the output FIFO has drained

`timescale 1ns/1ps

module merge_control (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  logic                         start,
    input  merge_pkg::merge_descriptor_t descriptor,
    input  logic                         merge_fire,
    input  logic                         out_almost_full,
    input  logic                         out_empty,
    output logic                         merge_enable,
    output merge_pkg::lane_vec_t         merge_mask,
    output logic                         busy,
    output logic                         done
);

    import merge_pkg::*;

    merge_state_t state;
    merge_state_t next_state;
    count_t       target_count;
    count_t       fire_count;
    logic         start_ok;
    logic         last_fire;
    logic         fire_q;

    assign start_ok  = start && (state == IDLE);
    assign last_fire = merge_fire && (count_t'(fire_count + 1'b1) == target_count);

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = (descriptor.packet_count == '0) ? DRAIN : BUSY;
                end
            end
            BUSY: begin
                if (last_fire) begin
                    next_state = DRAIN;
                end else if (out_almost_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (!out_almost_full) begin
                    next_state = BUSY;
                end
            end
            // Last merged packet lands in the FIFO one cycle after its fire
            DRAIN: begin
                if (out_empty && !fire_q) begin
                    next_state = DONE;
                end
            end
            DONE:    next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state      <= IDLE;
            fire_count <= '0;
            fire_q     <= 1'b0;
            merge_mask <= '1;
        end else begin
            state  <= next_state;
            fire_q <= merge_fire;
            if (start_ok) begin
                fire_count <= '0;
                merge_mask <= descriptor.merge_mask | lane_vec_t'(1);
            end else if (merge_fire) begin
                fire_count <= fire_count + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (start_ok) begin
            target_count <= descriptor.packet_count;
        end
    end

    assign merge_enable = (state == BUSY) && !out_almost_full;
    assign busy         = (state != IDLE);
    assign done         = (state == DONE);

endmodule

// File: merge_combiner.sv
// Merges the head packets of the enabled lanes
// Meta, field 0 and field 3 always come from lane 0
// Field j of lanes 1 and 2 is field 0 of lane j when that lane is enabled
// Masked lanes are drained in every enabled cycle, their data is dropped
// The merged packet and its write strobe appear one cycle after merge_fire

`timescale 1ns/1ps

module merge_combiner (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  merge_pkg::lane_packets_t lane_heads,
    input  merge_pkg::lane_vec_t     lane_empty,
    input  logic                     merge_enable,
    input  merge_pkg::lane_vec_t     merge_mask,
    output merge_pkg::lane_vec_t     lane_pop,
    output logic                     merge_fire,
    output logic                     out_write,
    output merge_pkg::packet_t       out_packet
);

    import merge_pkg::*;

    lane_vec_t lane_ready;
    packet_t   merged;

    // ------------------------------
    // Pop decision
    // ------------------------------
    // A lane is ready if it is masked out or holds a head
    assign lane_ready = ~merge_mask | ~lane_empty;
    assign merge_fire = merge_enable && (&lane_ready);

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            if (merge_mask[i]) begin
                lane_pop[i] = merge_fire;
            end else begin
                lane_pop[i] = merge_enable && !lane_empty[i];
            end
        end
    end

    // ------------------------------
    // Field selection
    // ------------------------------
    always_comb begin
        merged = lane_heads[0];
        for (int j = 1; j < num_lanes; j++) begin
            if (merge_mask[j]) begin
                merged.field[j] = lane_heads[j].field[0];
            end
        end
    end

    // Write strobe
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_write <= 1'b0;
        end else begin
            out_write <= merge_fire;
        end
    end

    // Payload held between merges
    always_ff @(posedge ap_clk) begin
        if (merge_fire) begin
            out_packet <= merged;
        end
    end

endmodule

// File: merge_output_port.sv
// Output FIFO with a credit-based sender
// The consumer starts with zero credits and returns one per out_credit cycle
// A credit that arrives in a cycle can be spent in that same cycle
// out_valid is high for one cycle per packet and uses one credit

`timescale 1ns/1ps

module merge_output_port (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               write,
    input  merge_pkg::packet_t write_packet,
    input  logic               out_credit,
    output logic               out_valid,
    output merge_pkg::packet_t out_packet,
    output logic               almost_full,
    output logic               empty
);

    import merge_pkg::*;

    packet_t fifo_head;
    count_t  credit_count;
    logic    credit_avail;
    logic    fifo_pop;

    packet_fifo #(
        .depth             (out_fifo_depth),
        .almost_full_level (out_almost_full_level)
    ) u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (write),
        .push_data        (write_packet),
        .pop              (fifo_pop),
        .head             (fifo_head),
        .empty            (empty),
        .almost_full      (almost_full)
    );

    // ------------------------------
    // Credit accounting
    // ------------------------------
    assign credit_avail = (credit_count != '0) || out_credit;
    assign fifo_pop     = !empty && credit_avail;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            credit_count <= '0;
            out_valid    <= 1'b0;
        end else begin
            credit_count <= credit_count + count_t'(out_credit) - count_t'(fifo_pop);
            out_valid    <= fifo_pop;
        end
    end

    // Registered output packet
    always_ff @(posedge ap_clk) begin
        if (fifo_pop) begin
            out_packet <= fifo_head;
        end
    end

endmodule

// File: merge_data_generator.sv
// Merge data generator for one lane of the graph engine
// Three input lanes, each with its own credit-controlled packet FIFO
// A producer may push only while it holds a credit, it starts with
// lane_fifo_depth credits and regains one per lane_credit cycle
// lane_credit is combinational from the lane FIFO state and run control
// start is ignored while busy is high

`timescale 1ns/1ps

module merge_data_generator (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  logic                         start,
    input  merge_pkg::merge_descriptor_t descriptor,
    input  merge_pkg::lane_vec_t         lane_push,
    input  merge_pkg::lane_packets_t     lane_data,
    output merge_pkg::lane_vec_t         lane_credit,
    input  logic                         out_credit,
    output logic                         out_valid,
    output merge_pkg::packet_t           out_packet,
    output logic                         busy,
    output logic                         done
);

    import merge_pkg::*;

    lane_packets_t lane_heads;
    lane_vec_t     lane_empty;
    lane_vec_t     lane_pop;
    lane_vec_t     merge_mask;
    logic          merge_enable;
    logic          merge_fire;
    logic          comb_write;
    packet_t       comb_packet;
    logic          out_almost_full;
    logic          out_empty;

    // ------------------------------
    // Input lane FIFOs
    // ------------------------------
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        packet_fifo #(
            .depth             (lane_fifo_depth),
            .almost_full_level (lane_fifo_depth)
        ) u_lane_fifo (
            .ap_clk           (ap_clk),
            .areset_generator (areset_generator),
            .push             (lane_push[i]),
            .push_data        (lane_data[i]),
            .pop              (lane_pop[i]),
            .head             (lane_heads[i]),
            .empty            (lane_empty[i]),
            .almost_full      ()
        );
    end

    // Every pop returns one credit to its producer
    assign lane_credit = lane_pop;

    // ------------------------------
    // Control, merge and output
    // ------------------------------
    merge_control u_merge_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .descriptor       (descriptor),
        .merge_fire       (merge_fire),
        .out_almost_full  (out_almost_full),
        .out_empty        (out_empty),
        .merge_enable     (merge_enable),
        .merge_mask       (merge_mask),
        .busy             (busy),
        .done             (done)
    );

    merge_combiner u_merge_combiner (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .lane_heads       (lane_heads),
        .lane_empty       (lane_empty),
        .merge_enable     (merge_enable),
        .merge_mask       (merge_mask),
        .lane_pop         (lane_pop),
        .merge_fire       (merge_fire),
        .out_write        (comb_write),
        .out_packet       (comb_packet)
    );

    merge_output_port u_merge_output_port (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .write            (comb_write),
        .write_packet     (comb_packet),
        .out_credit       (out_credit),
        .out_valid        (out_valid),
        .out_packet       (out_packet),
        .almost_full      (out_almost_full),
        .empty            (out_empty)
    );

endmodule

// File: merge_asserts.sv
// Bound checks on the credit and FIFO rules of the merge data generator
// Lane fill is tracked from pushes and credit pulses
// error_count counts failed assertions for the testbench

`timescale 1ns/1ps

module merge_asserts (
    input logic                 ap_clk,
    input logic                 areset_generator,
    input merge_pkg::lane_vec_t lane_push,
    input merge_pkg::lane_vec_t lane_credit,
    input logic                 out_credit,
    input logic                 out_valid,
    input logic                 busy,
    input logic                 done
);

    import merge_pkg::*;

    int error_count = 0;
    int lane_fill [num_lanes];
    int credits_granted;
    int packets_sent;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            for (int i = 0; i < num_lanes; i++) begin
                lane_fill[i] <= 0;
            end
            credits_granted <= 0;
            packets_sent    <= 0;
        end else begin
            for (int i = 0; i < num_lanes; i++) begin
                lane_fill[i] <= lane_fill[i] + int'(lane_push[i]) - int'(lane_credit[i]);
            end
            credits_granted <= credits_granted + int'(out_credit);
            packets_sent    <= packets_sent + int'(out_valid);
        end
    end

    // ------------------------------
    // Properties
    // ------------------------------
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane_chk
        lane_push_room: assert property (@(posedge ap_clk) disable iff (areset_generator)
            lane_push[i] |-> (lane_fill[i] < lane_fifo_depth))
        else begin
            $error("lane %0d pushed into a full FIFO", i);
            error_count++;
        end
    end

    out_within_credit: assert property (@(posedge ap_clk) disable iff (areset_generator)
        out_valid |-> (packets_sent < credits_granted))
    else begin
        $error("out_valid without an output credit");
        error_count++;
    end

    done_one_cycle: assert property (@(posedge ap_clk) disable iff (areset_generator)
        done |=> !done)
    else begin
        $error("done held for more than one cycle");
        error_count++;
    end

    quiet_after_reset: assert property (@(posedge ap_clk)
        areset_generator |=> (!busy && !done))
    else begin
        $error("busy or done high after reset");
        error_count++;
    end

endmodule

// Attach to every instance of the top level
bind merge_data_generator merge_asserts u_merge_asserts (.*);

// File: tb_merge_data_generator.sv
// Table-driven testbench for the merge data generator
// Producers hold lane credits across rows, output credits are granted per row
// A masked lane pushes only together with lane 0, so it is drained before
// the last merge of a run
// The consumer withholds credits for credit_hold cycles at the start of a row

`timescale 1ns/1ps

module tb_merge_data_generator;

    import merge_pkg::*;

    localparam int num_tests   = 5;
    localparam int run_timeout = 3000;

    // push_gap is the idle chance per cycle in 1/128 steps
    typedef struct packed {
        lane_vec_t  mask;
        count_t     packet_count;
        logic [6:0] push_gap;
        logic [7:0] credit_hold;
    } test_row_t;

    logic              ap_clk;
    logic              areset_generator;
    logic              start;
    merge_descriptor_t descriptor;
    lane_vec_t         lane_push;
    lane_packets_t     lane_data;
    lane_vec_t         lane_credit;
    logic              out_credit;
    logic              out_valid;
    packet_t           out_packet;
    logic              busy;
    logic              done;

    test_row_t   rows [num_tests];
    string       row_names [num_tests];
    string       cur_test;
    logic [31:0] lfsr_state;
    packet_t     lane0_q[$];
    packet_t     lane1_q[$];
    packet_t     lane2_q[$];
    int          lane_credits [num_lanes];
    int          pushed [num_lanes];
    int          returned [num_lanes];
    int          granted;
    int          received;
    int          hold_left;

    merge_data_generator u_merge_data_generator (.*);

    initial ap_clk = 1'b0;
    always #10 ap_clk = ~ap_clk;

    // ------------------------------
    // Random source and models
    // ------------------------------
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic packet_t random_packet();
        packet_t p;
        p.meta = meta_t'(rand_bits(meta_w));
        for (int f = 0; f < num_fields; f++) begin
            p.field[f] = field_t'(rand_bits(field_w));
        end
        return p;
    endfunction

    // Meta, field 0 and field 3 from lane 0, field j from lane j when enabled
    function automatic packet_t expected_merge(input packet_t h0, input packet_t h1,
                                               input packet_t h2, input lane_vec_t mask);
        packet_t p;
        p = h0;
        if (mask[1]) begin
            p.field[1] = h1.field[0];
        end
        if (mask[2]) begin
            p.field[2] = h2.field[0];
        end
        return p;
    endfunction

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "testbench stopped at its first failure");
    endtask

    task automatic fail_with(input string reason);
        $display("Test %s: %s", cur_test, reason);
        stop_on_failure();
    endtask

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s] %s: expected %0h, actual %0h",
                     cur_test, what, expected, actual);
            stop_on_failure();
        end
    endtask

    // ------------------------------
    // Producers and consumer
    // ------------------------------
    task automatic drive_lanes(input test_row_t row, input lane_vec_t mask);
        lane_vec_t credit_now;
        packet_t   p;
        int        quota;
        logic      gap_ok;
        credit_now = lane_credit;
        lane_push  = '0;
        for (int i = 0; i < num_lanes; i++) begin
            quota  = mask[i] ? int'(row.packet_count) : int'(row.packet_count) / 2;
            gap_ok = 7'(rand_bits(7)) >= row.push_gap;
            if (pushed[i] < quota && lane_credits[i] > 0 && gap_ok &&
                (mask[i] || lane_push[0])) begin
                p            = random_packet();
                lane_push[i] = 1'b1;
                lane_data[i] = p;
                lane_credits[i]--;
                pushed[i]++;
                if (i == 0) begin
                    lane0_q.push_back(p);
                end else if (i == 1 && mask[1]) begin
                    lane1_q.push_back(p);
                end else if (i == 2 && mask[2]) begin
                    lane2_q.push_back(p);
                end
            end
        end
        // A credit seen now is spent from the next cycle on
        for (int i = 0; i < num_lanes; i++) begin
            if (credit_now[i]) begin
                lane_credits[i]++;
                returned[i]++;
            end
        end
    endtask

    task automatic drive_consumer(input test_row_t row);
        out_credit = 1'b0;
        if (hold_left > 0) begin
            hold_left--;
        end else if (granted < int'(row.packet_count) && rand_bits(1) != 32'd0) begin
            out_credit = 1'b1;
            granted++;
        end
    endtask

    task automatic sample_outputs(input test_row_t row, input lane_vec_t mask,
                                  output logic done_seen);
        packet_t h0;
        packet_t h1;
        packet_t h2;
        done_seen = 1'b0;
        if (u_merge_data_generator.u_merge_asserts.error_count != 0) begin
            fail_with("a bound assertion failed");
        end
        if (out_valid) begin
            if (lane0_q.size() == 0) begin
                fail_with("out_valid with no merge pending in the model");
            end
            h0 = lane0_q.pop_front();
            h1 = '0;
            h2 = '0;
            if (mask[1]) begin
                h1 = lane1_q.pop_front();
            end
            if (mask[2]) begin
                h2 = lane2_q.pop_front();
            end
            received++;
            if (received > granted) begin
                fail_with("more out_valid pulses than output credits granted");
            end
            check_value("merged packet", 128'(expected_merge(h0, h1, h2, mask)),
                        128'(out_packet));
        end
        if (done) begin
            check_value("packets at done", 128'(row.packet_count), 128'(received));
            done_seen = 1'b1;
        end
    endtask

    task automatic run_test(input int idx);
        test_row_t row;
        lane_vec_t mask;
        logic      done_seen;
        int        cycles;
        row       = rows[idx];
        cur_test  = row_names[idx];
        mask      = row.mask | lane_vec_t'(1);
        granted   = 0;
        received  = 0;
        hold_left = int'(row.credit_hold);
        cycles    = 0;
        for (int i = 0; i < num_lanes; i++) begin
            pushed[i]   = 0;
            returned[i] = 0;
        end
        forever begin
            @(negedge ap_clk);
            sample_outputs(row, mask, done_seen);
            if (done_seen) begin
                break;
            end
            if (cycles == 0) begin
                check_value("busy before start", 128'(0), 128'(busy));
            end
            if (cycles == 1) begin
                check_value("busy after start", 128'(1), 128'(busy));
            end
            start                   = (cycles == 0);
            descriptor.merge_mask   = row.mask;
            descriptor.packet_count = row.packet_count;
            drive_lanes(row, mask);
            drive_consumer(row);
            cycles++;
            if (cycles > run_timeout) begin
                fail_with("no done pulse within the run timeout");
            end
        end
        lane_push  = '0;
        out_credit = 1'b0;
        @(negedge ap_clk);
        check_value("done after its pulse", 128'(0), 128'(done));
        check_value("busy after done", 128'(0), 128'(busy));
        for (int i = 0; i < num_lanes; i++) begin
            check_value($sformatf("lane %0d credits returned", i),
                        128'(pushed[i]), 128'(returned[i]));
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        lfsr_state       = 32'h4d7d;
        areset_generator = 1'b1;
        start            = 1'b0;
        descriptor       = '0;
        lane_push        = '0;
        lane_data        = '0;
        out_credit       = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            lane_credits[i] = lane_fifo_depth;
        end
        rows[0] = '{mask: 3'b111, packet_count: 16'd12, push_gap: 7'd20, credit_hold: 8'd0};
        rows[1] = '{mask: 3'b101, packet_count: 16'd10, push_gap: 7'd40, credit_hold: 8'd0};
        rows[2] = '{mask: 3'b011, packet_count: 16'd10, push_gap: 7'd30, credit_hold: 8'd3};
        rows[3] = '{mask: 3'b111, packet_count: 16'd16, push_gap: 7'd10, credit_hold: 8'd80};
        rows[4] = '{mask: 3'b000, packet_count: 16'd8, push_gap: 7'd50, credit_hold: 8'd5};
        row_names[0] = "all_lanes";
        row_names[1] = "lane1_masked";
        row_names[2] = "lane2_masked";
        row_names[3] = "credit_stall";
        row_names[4] = "lane0_only";
        repeat (10) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_generator = 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        if (u_merge_data_generator.u_merge_asserts.error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
merge_pkg.sv
packet_fifo.sv
merge_control.sv
merge_combiner.sv
merge_output_port.sv
merge_data_generator.sv
merge_asserts.sv
tb_merge_data_generator.sv

// File: Bender.yml
package:
  name: merge_data_generator

sources:
  - merge_pkg.sv
  - packet_fifo.sv
  - merge_control.sv
  - merge_combiner.sv
  - merge_output_port.sv
  - merge_data_generator.sv
  - target: test
    files:
      - merge_asserts.sv
      - tb_merge_data_generator.sv
